/* source/heapPkg.sv */
/*
  Heap memory shared types
  Action codes taken by the command port and error codes returned with each response
*/
package heapPkg;

  //----------------------------------------
  // Actions
  //----------------------------------------
  typedef enum logic [7:0] {
    actionWrite = 8'd2,                          // Write an element
    actionRead  = 8'd3,                          // Read an element
    actionSize  = 8'd4,                          // Current size of an array
    actionPush  = 8'd14,                         // Append at the end
    actionPop   = 8'd15,                         // Remove from the end
    actionAlloc = 8'd18,                         // Hand out an array number
    actionFree  = 8'd19,                         // Return an array number
    actionAdd   = 8'd20,                         // Add in place, new value back
    actionXor   = 8'd30                          // Xor in place, new value back
  } heapAction_t;

  //----------------------------------------
  // Errors
  //----------------------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,                      // Command done
    errNotAllocated = 3'd1,                      // Array never handed out or freed
    errOutOfBounds  = 3'd2,                      // Index at or past size
    errFull         = 3'd3,                      // Push onto a full array
    errEmpty        = 3'd4,                      // Pop from an empty array
    errOutOfMemory  = 3'd5,                      // Every array number in use
    errBadAction    = 3'd6                       // Unknown action code
  } heapError_t;

endpackage

/* source/heapCommandIf.sv */
/*
  Heap command link
  One command with a valid/ready pair, between port, queue and engine
*/
`timescale 1ns/10ps

interface heapCommandIf #(
  parameter int addressBits = 2,                 // Array number width
  parameter int indexBits   = 2,                 // Element index width
  parameter int dataBits    = 12                 // Element width
);
  import heapPkg::*;

  heapAction_t            action;                // What to do
  logic [addressBits-1:0] array;                 // Which array
  logic [indexBits-1:0]   index;                 // Which element
  logic [dataBits-1:0]    data;                  // Operand
  logic                   valid;                 // Command present
  logic                   ready;                 // Receiver can take it

  // Side that offers commands
  modport source (
    output action, array, index, data, valid,
    input  ready
  );

  // Side that takes commands
  modport sink (
    input  action, array, index, data, valid,
    output ready
  );

endinterface

/* source/heapRequestPort.sv */
/*
  Heap request port
  Four-phase req/ack slave, captures a command and pushes it into the queue
*/
`timescale 1ns/10ps

module heapRequestPort #(
  parameter int addressBits = 2,                 // Array number width
  parameter int indexBits   = 2,                 // Element index width
  parameter int dataBits    = 12                 // Element width
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req,            // Request from outside
  input  heapPkg::heapAction_t   action,         // Requested action
  input  logic [addressBits-1:0] array,          // Requested array
  input  logic [indexBits-1:0]   index,          // Requested element
  input  logic [dataBits-1:0]    data,           // Requested operand
  output logic                   ack,            // Command taken
  heapCommandIf.source           command         // Towards the queue
);
  import heapPkg::*;

  //----------------------------------------
  // Handshake FSM
  //----------------------------------------
  localparam logic [1:0] stateIdle    = 2'd0;    // Waiting for req
  localparam logic [1:0] statePushing = 2'd1;    // Offering to the queue
  localparam logic [1:0] stateAcked   = 2'd2;    // Waiting for req to fall

  logic [1:0] state;

  assign command.valid = (state == statePushing); // Offer while pushing
  assign ack           = (state == stateAcked);   // Held until req drops

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= stateIdle;
    end else begin
      case (state)
        stateIdle: begin
          if (req) state <= statePushing;        // Fields captured below
        end
        statePushing: begin
          if (command.ready) state <= stateAcked; // Queue took it
        end
        stateAcked: begin
          if (!req) state <= stateIdle;          // Requester released
        end
        default: state <= stateIdle;
      endcase
    end
  end

  // Command fields, loaded when a request is first seen
  always_ff @(posedge clock) begin
    if (state == stateIdle && req) begin
      command.action <= action;
      command.array  <= array;
      command.index  <= index;
      command.data   <= data;
    end
  end

  // Ack must only answer a live request
  ackFollowsReq: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> req)
    else $error("ack rose while req was low");

endmodule

/* source/heapCommandQueue.sv */
/*
  Heap command queue
  Circular FIFO of commands accepted from the port and not yet executed
*/
`timescale 1ns/10ps

module heapCommandQueue #(
  parameter int addressBits = 2,                 // Array number width
  parameter int indexBits   = 2,                 // Element index width
  parameter int dataBits    = 12,                // Element width
  parameter int queueDepth  = 4                  // Entries
) (
  input  logic         clock,
  input  logic         reset,
  heapCommandIf.sink   upstream,                 // From the request port
  heapCommandIf.source downstream                // To the engine
);
  import heapPkg::*;

  localparam int pointerBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int countBits   = $clog2(queueDepth + 1);

  //----------------------------------------
  // Storage
  //----------------------------------------
  heapAction_t            actionStore [queueDepth];
  logic [addressBits-1:0] arrayStore  [queueDepth];
  logic [indexBits-1:0]   indexStore  [queueDepth];
  logic [dataBits-1:0]    dataStore   [queueDepth];

  logic [pointerBits-1:0] writePointer;          // Next free slot
  logic [pointerBits-1:0] readPointer;           // Oldest entry
  logic [countBits-1:0]   count;                 // Entries held
  logic                   push;
  logic                   pop;

  assign upstream.ready   = (count != countBits'(queueDepth)); // Room left
  assign downstream.valid = (count != '0);       // Something to hand out
  assign push = upstream.valid && upstream.ready;
  assign pop  = downstream.valid && downstream.ready;

  assign downstream.action = actionStore[readPointer];
  assign downstream.array  = arrayStore[readPointer];
  assign downstream.index  = indexStore[readPointer];
  assign downstream.data   = dataStore[readPointer];

  always_ff @(posedge clock) begin
    if (push) begin
      actionStore[writePointer] <= upstream.action;
      arrayStore[writePointer]  <= upstream.array;
      indexStore[writePointer]  <= upstream.index;
      dataStore[writePointer]   <= upstream.data;
    end
  end

  //----------------------------------------
  // Pointers and count
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      writePointer <= '0;
      readPointer  <= '0;
      count        <= '0;
    end else begin
      if (push) begin                            // Wrap at depth, not at a power of two
        writePointer <= (writePointer == pointerBits'(queueDepth - 1)) ? '0
                        : writePointer + 1'b1;
      end
      if (pop) begin
        readPointer <= (readPointer == pointerBits'(queueDepth - 1)) ? '0
                       : readPointer + 1'b1;
      end
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  countInRange: assert property (@(posedge clock) disable iff (reset)
    count <= countBits'(queueDepth))
    else $error("queue count above depth");

  // Equal pointers mean empty unless the count says full
  noPopWhenEmpty: assert property (@(posedge clock) disable iff (reset)
    pop |-> (readPointer != writePointer || count == countBits'(queueDepth)))
    else $error("pop from an empty queue");

endmodule

/* source/heapArrayEngine.sv */
/*
  Heap array engine
  Holds arrays, sizes and the allocation state, executes one command per cycle
  and registers the response one cycle later
*/
`timescale 1ns/10ps

module heapArrayEngine #(
  parameter int addressBits = 2,                 // Array number width
  parameter int indexBits   = 2,                 // Element index width
  parameter int dataBits    = 12                 // Element width
) (
  input  logic                clock,
  input  logic                reset,
  heapCommandIf.sink          command,           // From the queue
  output logic                respValid,         // Response present this cycle
  output logic [dataBits-1:0] result,            // Result word
  output heapPkg::heapError_t error              // Error code
);
  import heapPkg::*;

  localparam int arrays      = 2**addressBits;
  localparam int arrayLength = 2**indexBits;

  //----------------------------------------
  // State
  //----------------------------------------
  logic [dataBits-1:0]    memory [arrays][arrayLength]; // Elements in fixed blocks
  logic [indexBits:0]     sizes [arrays];        // Size per array
  logic [addressBits-1:0] freeStack [arrays];    // Freed numbers, newest on top
  logic [arrays-1:0]      allocated;             // One flag per array
  logic [addressBits:0]   freshCount;            // Numbers handed out fresh
  logic [addressBits:0]   freeTop;               // Free stack depth

  logic                   accept;                // Command taken this cycle
  logic                   done;                  // Taken and no error
  logic                   isAllocated;
  logic [indexBits:0]     currentSize;
  logic [indexBits-1:0]   tailIndex;             // Slot at the current size
  logic [indexBits-1:0]   popIndex;              // Slot at size minus one
  logic [dataBits-1:0]    element;
  logic [dataBits-1:0]    topElement;
  logic [addressBits:0]   belowTop;
  logic                   reuse;                 // Free stack not empty
  logic [addressBits-1:0] newNumber;             // Number Alloc would give
  heapError_t             fault;
  logic [dataBits-1:0]    value;

  assign command.ready = 1'b1;                   // Engine never stalls
  assign accept        = command.valid && command.ready;
  assign done          = accept && (fault == errNone);

  assign isAllocated = allocated[command.array];
  assign currentSize = sizes[command.array];
  assign tailIndex   = currentSize[indexBits-1:0];
  assign popIndex    = tailIndex - 1'b1;         // Wraps right for a full array
  assign element     = memory[command.array][command.index];
  assign topElement  = memory[command.array][popIndex];

  assign belowTop  = freeTop - 1'b1;
  assign reuse     = (freeTop != '0);
  assign newNumber = reuse ? freeStack[belowTop[addressBits-1:0]]
                     : freshCount[addressBits-1:0];

  //----------------------------------------
  // Checks, then the result word
  //----------------------------------------
  always_comb begin
    fault = errNone;
    value = '0;
    case (command.action)
      actionAlloc: begin
        if (!reuse && freshCount[addressBits]) fault = errOutOfMemory; // All numbers used
      end
      actionWrite, actionSize, actionFree: begin
        if (!isAllocated) fault = errNotAllocated;
      end
      actionRead, actionAdd, actionXor: begin
        if (!isAllocated) fault = errNotAllocated;
        else if ({1'b0, command.index} >= currentSize) fault = errOutOfBounds;
      end
      actionPush: begin
        if (!isAllocated) fault = errNotAllocated;
        else if (currentSize[indexBits]) fault = errFull; // Size equals length
      end
      actionPop: begin
        if (!isAllocated) fault = errNotAllocated;
        else if (currentSize == '0) fault = errEmpty;
      end
      default: fault = errBadAction;
    endcase

    if (fault == errNone) begin                  // Zero result on any error
      case (command.action)
        actionAlloc: value = dataBits'(newNumber);
        actionWrite,
        actionPush:  value = command.data;
        actionRead:  value = element;
        actionSize:  value = dataBits'(currentSize);
        actionPop:   value = topElement;
        actionAdd:   value = element + command.data; // Wraps at dataBits
        actionXor:   value = element ^ command.data;
        default:     value = '0;
      endcase
    end
  end

  //----------------------------------------
  // Elements, sizes and response payload
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (accept) begin
      result <= value;
      error  <= fault;
    end
    if (done) begin
      case (command.action)
        actionAlloc: sizes[newNumber] <= '0;     // Starts empty
        actionFree:  freeStack[freeTop[addressBits-1:0]] <= command.array;
        actionWrite: begin
          memory[command.array][command.index] <= command.data;
          if ({1'b0, command.index} >= currentSize) begin
            sizes[command.array] <= {1'b0, command.index} + 1'b1; // Grow to cover index
          end
        end
        actionPush: begin
          memory[command.array][tailIndex] <= command.data;
          sizes[command.array] <= currentSize + 1'b1;
        end
        actionPop: sizes[command.array] <= currentSize - 1'b1;
        actionAdd,
        actionXor:   memory[command.array][command.index] <= value;
        default: ;
      endcase
    end
  end

  //----------------------------------------
  // Allocation control
  //----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      respValid  <= 1'b0;
      allocated  <= '0;
      freshCount <= '0;
      freeTop    <= '0;
    end else begin
      respValid <= accept;                       // One response per command
      if (done && command.action == actionAlloc) begin
        allocated[newNumber] <= 1'b1;
        if (reuse) freeTop <= belowTop;          // Newest freed first
        else freshCount <= freshCount + 1'b1;
      end
      if (done && command.action == actionFree) begin
        allocated[command.array] <= 1'b0;
        freeTop <= freeTop + 1'b1;
      end
    end
  end

  // Live arrays equal fresh numbers minus those waiting on the free stack
  allocationCount: assert property (@(posedge clock) disable iff (reset)
    $countones(allocated) == int'(freshCount) - int'(freeTop))
    else $error("allocation flags disagree with fresh count and free stack");

  // Free stack and fresh count never hand out a live array
  allocUnique: assert property (@(posedge clock) disable iff (reset)
    (done && command.action == actionAlloc) |-> !allocated[newNumber])
    else $error("alloc returned an array in use");

endmodule

/* source/heapMemory.sv */
/*
  Heap memory top level
  Request port, command queue and array engine behind a req/ack handshake
*/
`timescale 1ns/10ps

module heapMemory #(
  parameter int addressBits = 2,                 // 2**addressBits arrays
  parameter int indexBits   = 2,                 // 2**indexBits elements each
  parameter int dataBits    = 12,                // Element width
  parameter int queueDepth  = 4                  // Commands in flight
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req,            // Four-phase request
  input  logic [7:0]             action,         // Raw action code
  input  logic [addressBits-1:0] array,
  input  logic [indexBits-1:0]   index,
  input  logic [dataBits-1:0]    data,
  output logic                   ack,            // Four-phase acknowledge
  output logic                   respValid,      // One cycle per response
  output logic [dataBits-1:0]    result,
  output heapPkg::heapError_t    error
);
  import heapPkg::*;

  heapAction_t requestAction;                    // Unknown codes pass through

  assign requestAction = heapAction_t'(action);

  heapCommandIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    requestLink ();                              // Port to queue
  heapCommandIf #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    engineLink ();                               // Queue to engine

  heapRequestPort #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    requestPort (
      .clock   (clock),
      .reset   (reset),
      .req     (req),
      .action  (requestAction),
      .array   (array),
      .index   (index),
      .data    (data),
      .ack     (ack),
      .command (requestLink)
    );

  heapCommandQueue #(
    .addressBits (addressBits),
    .indexBits   (indexBits),
    .dataBits    (dataBits),
    .queueDepth  (queueDepth)
  ) commandQueue (
    .clock      (clock),
    .reset      (reset),
    .upstream   (requestLink),
    .downstream (engineLink)
  );

  heapArrayEngine #(.addressBits(addressBits), .indexBits(indexBits), .dataBits(dataBits))
    arrayEngine (
      .clock     (clock),
      .reset     (reset),
      .command   (engineLink),
      .respValid (respValid),
      .result    (result),
      .error     (error)
    );

endmodule

/* verif/heapMemoryTb.sv */
/*
  Heap memory testbench
  Sends each command from the vector file through the req/ack handshake
  and checks every response in order
*/
`timescale 1ns/10ps

module heapMemoryTb;

  localparam int maxVectors  = 64;               // Room in the vector table
  localparam int fields      = 6;                // Words per vector line
  localparam int burstLength = 6;                // Tail sent with no idle gap

  logic        clock;
  logic        reset;
  logic        req;
  logic [7:0]  action;
  logic [1:0]  array;
  logic [1:0]  index;
  logic [11:0] data;
  logic        ack;
  logic        respValid;
  logic [11:0] result;
  logic [2:0]  error;

  logic [15:0] vectorWords [maxVectors*fields];  // Flat table, six words per vector
  int          vectorCount;
  int          responseCount;                    // Responses seen so far
  int          valueErrors;
  int          otherErrors;
  int          cycleCount;
  int          cycleLimit;
  int          seed;
  int          gap;

  heapMemory heapMemory_inst (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .action    (action),
    .array     (array),
    .index     (index),
    .data      (data),
    .ack       (ack),
    .respValid (respValid),
    .result    (result),
    .error     (error)
  );

  //----------------------------------------
  // Clock and cycle limit
  //----------------------------------------
  always #10 clock = ~clock;                     // 20 ns period

  always @(posedge clock) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      otherErrors = otherErrors + 1;
      $display("Timeout after %0d cycles, only %0d of %0d responses seen",
               cycleCount, responseCount, vectorCount);
      printCounts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------
  task automatic loadVectors();
    for (int i = 0; i < maxVectors*fields; i++) begin
      vectorWords[i] = 16'hF000 | 16'(i);        // Top nibble F marks an unused slot
    end
    $readmemh("verif/heapVectors.txt", vectorWords);
    vectorCount = 0;
    while (vectorCount < maxVectors && vectorWords[vectorCount*fields][15:12] != 4'hF) begin
      vectorCount = vectorCount + 1;
    end
  endtask

  // Four-phase cycle for one vector, returns just after ack falls
  task automatic sendCommand(input int v);
    int base;
    base = v * fields;
    action <= vectorWords[base][7:0];
    array  <= vectorWords[base+1][1:0];
    index  <= vectorWords[base+2][1:0];
    data   <= vectorWords[base+3][11:0];
    req    <= 1'b1;
    @(posedge clock);
    while (!ack) @(posedge clock);               // Held high under back-pressure
    req <= 1'b0;
    @(posedge clock);
    while (ack) @(posedge clock);
  endtask

  function automatic void printCounts();
    $display("Errors: %0d wrong values, %0d other failures, %0d of %0d responses",
             valueErrors, otherErrors, responseCount, vectorCount);
  endfunction

  //----------------------------------------
  // Response checker
  //----------------------------------------
  always @(posedge clock) begin : checkResponses
    int base;
    if (!reset && respValid) begin
      if (responseCount >= vectorCount) begin
        otherErrors = otherErrors + 1;
        $display("Response %0d arrived with no vector left to match it", responseCount);
      end else begin
        base = responseCount * fields;
        assert (result == vectorWords[base+4][11:0]) else begin
          valueErrors = valueErrors + 1;
          $display("ERR %0t: vector %0d result %h, expected %h",
                   $time, responseCount, result, vectorWords[base+4][11:0]);
        end
        assert (error == vectorWords[base+5][2:0]) else begin
          valueErrors = valueErrors + 1;
          $display("ERR %0t: vector %0d error %0d, expected %0d",
                   $time, responseCount, error, vectorWords[base+5][2:0]);
        end
      end
      responseCount = responseCount + 1;         // In order, one per command
    end
  end

  //----------------------------------------
  // Stimulus
  //----------------------------------------
  initial begin
    clock         = 1'b0;
    cycleCount    = 0;
    cycleLimit    = 0;
    responseCount = 0;
    valueErrors   = 0;
    otherErrors   = 0;
    seed          = 32'h606b;
    reset  <= 1'b1;
    req    <= 1'b0;
    action <= 8'h00;
    array  <= 2'd0;
    index  <= 2'd0;
    data   <= 12'h000;
    loadVectors();
    if (vectorCount == 0) begin
      otherErrors = otherErrors + 1;
      $display("No vectors could be read from verif/heapVectors.txt");
    end
    cycleLimit = vectorCount * 12 + 20;          // Handshake plus worst gap per vector
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int v = 0; v < vectorCount; v++) begin
      sendCommand(v);
      if (v < vectorCount - burstLength) begin
        gap = $random(seed) & 3;                 // Idle 0 to 3 cycles
        repeat (gap) @(posedge clock);
      end
    end
    while (responseCount < vectorCount) @(posedge clock);
    repeat (4) @(posedge clock);                 // Room for a stray extra response
    printCounts();
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verif/heapVectors.txt */
// action array index data result error, all hex, one command per line
// the last six lines are sent back to back with no idle gap
03 0 0 000 000 1
12 0 0 000 000 0
12 0 0 000 001 0
12 0 0 000 002 0
12 0 0 000 003 0
12 0 0 000 000 5
13 2 0 000 000 0
13 1 0 000 000 0
12 0 0 000 001 0
12 0 0 000 002 0
02 0 1 123 123 0
03 0 1 000 123 0
02 1 2 abc abc 0
04 1 0 000 003 0
03 1 3 000 000 2
0e 3 0 011 011 0
0e 3 0 022 022 0
04 3 0 000 002 0
0e 3 0 033 033 0
0e 3 0 044 044 0
04 3 0 000 004 0
0e 3 0 055 000 3
0f 3 0 000 044 0
0f 3 0 000 033 0
0f 3 0 000 022 0
0f 3 0 000 011 0
0f 3 0 000 000 4
14 0 1 fff 122 0
03 0 1 000 122 0
1e 0 1 0f0 1d2 0
03 0 1 000 1d2 0
13 2 0 000 000 0
03 2 0 000 000 1
13 2 0 000 000 1
05 0 0 000 000 6
12 0 0 000 002 0
0e 2 0 101 101 0
0e 2 0 102 102 0
0f 2 0 000 102 0
04 2 0 000 001 0
03 2 0 000 101 0

/* vlog.f */
source/heapPkg.sv
source/heapCommandIf.sv
source/heapRequestPort.sv
source/heapCommandQueue.sv
source/heapArrayEngine.sv
source/heapMemory.sv
verif/heapMemoryTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the heap memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module heapMemoryTb -o heapMemorySim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/heapMemorySim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1
